/* can_defines.svh */
`ifndef CAN_DEFINES_SVH
`define CAN_DEFINES_SVH

// ==========================================================================
// CAN 2.0 frame field lengths and limits
// ==========================================================================

// Identifier lengths
`define CAN_LEN_ID_A 11
`define CAN_LEN_ID_B 18

// Control and data field
`define CAN_LEN_DLC 4
`define CAN_MAX_BYTES 8

// CRC-15 with zero start value
`define CAN_LEN_CRC 15
`define CAN_CRC_POLY 15'h4599

// Frame tail
`define CAN_LEN_EOF 7
`define CAN_LEN_INTERFRAME 2

// Bit stream rules
`define CAN_STUFF_RUN 5
`define CAN_IDLE_RUN 11

`endif

/* can_frame_pkg.sv */
`include "can_defines.svh"

package can_frame_pkg;

	// ==========================================================================
	// Frame content as seen by the host
	// ==========================================================================

	// One 29-bit identifier word, decoded per IDE
	typedef union packed
	{
		struct packed
		{
			logic [`CAN_LEN_ID_B-1:0] unused; // Stays zero for a standard frame
			logic [`CAN_LEN_ID_A-1:0] id;
		} std;
		struct packed
		{
			logic [`CAN_LEN_ID_A-1:0] id_a; // Sent first on the bus
			logic [`CAN_LEN_ID_B-1:0] id_b;
		} ext;
	} can_id_t;

	// Result word of one good frame
	typedef struct packed
	{
		can_id_t id;
		logic ide; // Extended format
		logic rtr; // Remote request, no data
		logic [`CAN_LEN_DLC-1:0] dlc; // Never above 8
		// First received byte in the top byte
		// Bytes beyond dlc read as zero
		logic [`CAN_MAX_BYTES*8-1:0] data;
	} can_frame_t;

endpackage

/* can_ctrl_pkg.sv */
package can_ctrl_pkg;

	// One sampled bus bit after destuffing
	typedef struct packed
	{
		logic valid; // Sample strobe
		logic value; // Bus level, 0 is dominant
		logic stuff; // Stuff bit, to be dropped
	} can_bit_t;

	// Frame sequencer states in bus order
	typedef enum logic [4:0]
	{
		idle,
		id_a,
		rtr_srr, // RTR of standard frame or SRR of extended
		ide,
		id_b,
		rtr,
		res1,
		res0,
		dlc,
		data,
		crc,
		crc_delim,
		ack_slot,
		ack_delim,
		eof,
		interframe,
		error_wait // Waits for bus idle
	} can_state_e;

	typedef enum logic [1:0] {err_none, err_stuff, err_form, err_crc} can_error_e;

endpackage

/* can_bit_destuffer.sv */
`include "can_defines.svh"

module can_bit_destuffer
	import can_ctrl_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     rx_bit,
	input  logic     sample_point,
	input  logic     stuff_window,
	output can_bit_t bit_event,
	output logic     stuff_error
);

	localparam int RUN_W = $clog2(`CAN_STUFF_RUN + 1);

	logic [RUN_W-1:0] run_count; // Length of current run of equal bits
	logic last_bit; // Level of that run
	logic stuff_due; // Current bit must be a stuff bit
	logic new_run;

	// Full run inside the window, so this bit is inserted by the sender
	assign stuff_due = stuff_window && (run_count == RUN_W'(`CAN_STUFF_RUN));

	// Sixth equal bit
	assign stuff_error = sample_point && stuff_due && (rx_bit == last_bit);

	always_comb
	begin
		bit_event.valid = sample_point;
		bit_event.value = rx_bit;
		bit_event.stuff = stuff_due;
	end

	// Outside the window every bit seeds a run, so SOF counts as bit one
	// A stuff bit always opens a fresh run
	assign new_run = !stuff_window || stuff_due || (rx_bit != last_bit);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			run_count <= '0;
			last_bit <= 1'b1; // Recessive bus
		end
		else if (sample_point)
		begin
			last_bit <= rx_bit;
			if (new_run)
				run_count <= RUN_W'(1);
			else
				run_count <= run_count + 1'b1;
		end
	end

endmodule

/* can_frame_sequencer.sv */
`include "can_defines.svh"

module can_frame_sequencer
	import can_ctrl_pkg::*;
(
	input  logic                    clock,
	input  logic                    reset,
	input  can_bit_t                bit_event,
	input  logic                    stuff_error,
	input  logic                    crc_match,
	input  logic [`CAN_LEN_DLC-1:0] dlc, // Partial while the DLC field shifts in
	output can_state_e              state,
	output logic [5:0]              bit_index,
	output logic                    stuff_window,
	output logic                    frame_valid,
	output logic                    error_valid,
	output can_error_e              error_code
);

	// Index of the last bit of each multi-bit field
	localparam logic [5:0] last_id_a = 6'(`CAN_LEN_ID_A - 1);
	localparam logic [5:0] last_id_b = 6'(`CAN_LEN_ID_B - 1);
	localparam logic [5:0] last_dlc = 6'(`CAN_LEN_DLC - 1);
	localparam logic [5:0] last_crc = 6'(`CAN_LEN_CRC - 1);
	localparam logic [5:0] last_eof = 6'(`CAN_LEN_EOF - 1);
	localparam logic [5:0] last_idle = 6'(`CAN_IDLE_RUN - 1);
	localparam logic [5:0] sof_slot = 6'(`CAN_LEN_INTERFRAME); // Third intermission bit

	can_state_e state_next;
	logic [5:0] index_next;
	logic [5:0] data_last;
	logic rtr_flag; // SRR first, then RTR on extended frames
	logic form_bad;
	logic crc_bad;
	logic frame_done;

	// dlc is 1..8 here, 8 wraps to 7 in three bits
	assign data_last = {dlc[2:0] - 3'd1, 3'b111};

	// Includes the delimiter slot, where a stuff bit may follow the last CRC bit
	assign stuff_window = state inside {id_a, rtr_srr, ide, id_b, rtr, res1, res0,
		can_ctrl_pkg::dlc, data, crc, crc_delim};

	// ==========================================================================
	// Next field and form checks
	// ==========================================================================

	always_comb
	begin
		state_next = state;
		index_next = bit_index + 1'b1; // Next bit of the same field
		form_bad = 1'b0;
		crc_bad = 1'b0;
		frame_done = 1'b0;
		case (state)
			idle:
			begin
				index_next = '0;
				if (!bit_event.value)
					state_next = id_a; // SOF
			end
			id_a:
				if (bit_index == last_id_a)
					state_next = rtr_srr;
			rtr_srr: state_next = ide;
			ide:
			begin
				if (bit_event.value)
				begin
					form_bad = !rtr_flag; // SRR must be recessive
					state_next = id_b;
				end
				else
					state_next = res0; // Standard frame has r0 only
			end
			id_b:
				if (bit_index == last_id_b)
					state_next = rtr;
			rtr: state_next = res1;
			res1: state_next = res0;
			res0: state_next = can_ctrl_pkg::dlc;
			can_ctrl_pkg::dlc:
			begin
				// Remote frame or DLC of zero skips the data field
				if (bit_index == last_dlc)
				begin
					if (rtr_flag || ({dlc[2:0], bit_event.value} == 4'd0))
						state_next = crc;
					else
						state_next = data;
				end
			end
			data:
				if (bit_index == data_last)
					state_next = crc;
			crc:
				if (bit_index == last_crc)
					state_next = crc_delim;
			crc_delim:
			begin
				form_bad = !bit_event.value;
				crc_bad = !crc_match;
				state_next = ack_slot;
			end
			ack_slot:
			begin
				form_bad = bit_event.value; // Some receiver must acknowledge
				state_next = ack_delim;
			end
			ack_delim:
			begin
				form_bad = !bit_event.value;
				state_next = eof;
			end
			eof:
			begin
				form_bad = !bit_event.value;
				if (bit_index == last_eof)
				begin
					frame_done = 1'b1;
					state_next = interframe;
				end
			end
			interframe:
			begin
				if (bit_index == sof_slot)
					state_next = bit_event.value ? idle : id_a; // Back-to-back SOF
				else
					form_bad = !bit_event.value;
			end
			error_wait:
			begin
				// bit_index counts recessive bits here
				if (!bit_event.value)
					index_next = '0;
				else if (bit_index == last_idle)
					state_next = idle;
			end
			default: state_next = idle;
		endcase
		if (state_next != state)
			index_next = '0; // New field
	end

	// ==========================================================================
	// State register and result pulses
	// ==========================================================================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= idle;
			bit_index <= '0;
			rtr_flag <= 1'b0;
			frame_valid <= 1'b0;
			error_valid <= 1'b0;
			error_code <= err_none;
		end
		else
		begin
			frame_valid <= 1'b0; // Single-cycle pulses
			error_valid <= 1'b0;
			if (bit_event.valid && stuff_error)
			begin
				state <= error_wait;
				bit_index <= '0;
				error_valid <= 1'b1;
				error_code <= err_stuff;
			end
			else if (bit_event.valid && !bit_event.stuff)
			begin
				if (form_bad || crc_bad)
				begin
					state <= error_wait;
					bit_index <= '0;
					error_valid <= 1'b1;
					error_code <= form_bad ? err_form : err_crc; // Form wins
				end
				else
				begin
					state <= state_next;
					bit_index <= index_next;
					frame_valid <= frame_done;
				end
				if (state == rtr_srr || state == rtr)
					rtr_flag <= bit_event.value;
			end
		end
	end

endmodule

/* can_field_capture.sv */
`include "can_defines.svh"

module can_field_capture
	import can_frame_pkg::*;
	import can_ctrl_pkg::*;
(
	input  logic                    clock,
	input  logic                    reset,
	input  can_bit_t                bit_event,
	input  can_state_e              state,
	input  logic [5:0]              bit_index,
	output can_frame_t              frame,
	output logic [`CAN_LEN_DLC-1:0] dlc,
	output logic                    crc_match
);

	localparam int DATA_W = `CAN_MAX_BYTES * 8;
	localparam logic [5:0] last_eof = 6'(`CAN_LEN_EOF - 1);

	can_frame_t work; // Frame being received
	logic [`CAN_LEN_CRC-1:0] crc_reg; // Running CRC
	logic [`CAN_LEN_CRC-1:0] crc_rx; // CRC field from the bus
	logic [`CAN_LEN_CRC-1:0] crc_next;
	logic [`CAN_LEN_DLC-1:0] dlc_shift;
	logic take; // Unstuffed bit this cycle
	logic sof;
	logic crc_covered;

	assign take = bit_event.valid && !bit_event.stuff;
	assign sof = take && !bit_event.value && (state == idle || state == interframe);

	// SOF is dominant, so a zero CRC stays zero over it
	assign crc_covered = state inside {id_a, rtr_srr, ide, id_b, rtr, res1, res0,
		can_ctrl_pkg::dlc, data};

	// CRC-15 shift, feedback from the MSB
	assign crc_next = {crc_reg[`CAN_LEN_CRC-2:0], 1'b0}
		^ ((bit_event.value ^ crc_reg[`CAN_LEN_CRC-1]) ? `CAN_CRC_POLY : '0);
	assign crc_match = (crc_reg == crc_rx);

	assign dlc = work.dlc;
	assign dlc_shift = {work.dlc[`CAN_LEN_DLC-2:0], bit_event.value};

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			crc_reg <= '0;
			crc_rx <= '0;
		end
		else if (sof)
		begin
			crc_reg <= '0;
			crc_rx <= '0;
		end
		else if (take && crc_covered)
			crc_reg <= crc_next;
		else if (take && state == crc)
			crc_rx <= {crc_rx[`CAN_LEN_CRC-2:0], bit_event.value};
	end

	// ==========================================================================
	// Field shifting
	// ==========================================================================

	always_ff @(posedge clock)
	begin
		if (sof)
			work <= '0; // Also zeroes data bytes that never arrive
		else if (take)
		begin
			case (state)
				id_a, id_b: work.id <= {work.id[$bits(can_id_t)-2:0], bit_event.value};
				rtr_srr: work.rtr <= bit_event.value; // Overwritten on extended frames
				ide: work.ide <= bit_event.value;
				rtr: work.rtr <= bit_event.value;
				can_ctrl_pkg::dlc:
					work.dlc <= (dlc_shift > `CAN_MAX_BYTES) ? `CAN_LEN_DLC'(`CAN_MAX_BYTES)
						: dlc_shift;
				data: work.data[6'(DATA_W - 1) - bit_index] <= bit_event.value; // MSB first
				default: ;
			endcase
		end
	end

	// Publish on a good last EOF bit
	always_ff @(posedge clock)
	begin
		if (take && state == eof && bit_index == last_eof && bit_event.value)
			frame <= work;
	end

endmodule

/* can_decoder_top.sv */
`include "can_defines.svh"

module can_decoder_top
	import can_frame_pkg::*;
	import can_ctrl_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  logic       rx_bit,
	input  logic       sample_point,
	output can_frame_t frame,
	output logic       frame_valid,
	output can_error_e error_code,
	output logic       error_valid
);

	can_bit_t bit_event;
	logic stuff_error;
	logic stuff_window;
	can_state_e state;
	logic [5:0] bit_index;
	logic crc_match;
	logic [`CAN_LEN_DLC-1:0] dlc;

	// Decode stage
	can_bit_destuffer u_destuffer
	(
		.clock(clock),
		.reset(reset),
		.rx_bit(rx_bit),
		.sample_point(sample_point),
		.stuff_window(stuff_window),
		.bit_event(bit_event),
		.stuff_error(stuff_error)
	);

	// Execute stage
	can_frame_sequencer u_sequencer
	(
		.clock(clock),
		.reset(reset),
		.bit_event(bit_event),
		.stuff_error(stuff_error),
		.crc_match(crc_match),
		.dlc(dlc),
		.state(state),
		.bit_index(bit_index),
		.stuff_window(stuff_window),
		.frame_valid(frame_valid),
		.error_valid(error_valid),
		.error_code(error_code)
	);

	// Result stage
	can_field_capture u_capture
	(
		.clock(clock),
		.reset(reset),
		.bit_event(bit_event),
		.state(state),
		.bit_index(bit_index),
		.frame(frame),
		.dlc(dlc),
		.crc_match(crc_match)
	);

endmodule

/* tb_can_decoder.sv */
`include "can_defines.svh"

module tb_can_decoder
	import can_frame_pkg::*;
	import can_ctrl_pkg::*;
();

	// ==========================================================================
	// Run limits
	// ==========================================================================

	localparam int clock_period = 8;
	localparam int bit_clocks = 4; // Clocks per bus bit
	localparam int frame_total = 24; // Frames sent over all tests
	localparam int max_frame_bits = 160; // Extended, 8 bytes, worst stuffing
	localparam int gap_bits = 2 * `CAN_IDLE_RUN; // Idle and recovery bits per frame
	localparam longint watchdog_time = longint'(frame_total) * (max_frame_bits + gap_bits)
		* bit_clocks * clock_period + 4000;
	localparam int result_wait = 16 * bit_clocks; // Clocks to wait for a pulse
	localparam int full_ifs = `CAN_LEN_INTERFRAME + 1;

	logic clock;
	logic reset;
	logic rx_bit;
	logic sample_point;
	can_frame_t frame;
	logic frame_valid;
	can_error_e error_code;
	logic error_valid;

	logic raw_bits[$]; // Unstuffed, SOF through CRC
	logic tx_bits[$]; // Bits as sent on the wire
	int stuff_pos[$]; // Stuff bit positions in tx_bits
	can_frame_t got_frames[$];
	can_error_e got_errors[$];

	can_decoder_top dut0
	(
		.clock(clock),
		.reset(reset),
		.rx_bit(rx_bit),
		.sample_point(sample_point),
		.frame(frame),
		.frame_valid(frame_valid),
		.error_code(error_code),
		.error_valid(error_valid)
	);

	always #(clock_period / 2) clock = ~clock;

	// Pulses collected mid-cycle, away from the active edge
	always @(negedge clock)
	begin
		if (frame_valid === 1'b1)
			got_frames.push_back(frame);
		if (error_valid === 1'b1)
			got_errors.push_back(error_code);
	end

	initial
	begin
		#(watchdog_time);
		$display("Watchdog expired, the tests did not finish in time");
		$display("RESULT: FAIL");
		$fatal(1, "Watchdog");
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "Check failed");
	endtask

	// ==========================================================================
	// Bit level driver and frame builder
	// ==========================================================================

	// One bus bit over four clocks, strobe in the third
	task automatic drive_bit(input logic value);
		@(posedge clock);
		#1 rx_bit = value;
		repeat (2) @(posedge clock);
		#1 sample_point = 1'b1;
		@(posedge clock);
		#1 sample_point = 1'b0;
	endtask

	task automatic send_idle(input int count);
		repeat (count)
			drive_bit(1'b1); // Recessive
	endtask

	task automatic send_tx();
		int i;
		for (i = 0; i < tx_bits.size(); i++)
			drive_bit(tx_bits[i]);
	endtask

	task automatic push_field(input logic [63:0] value, input int width);
		int i;
		for (i = width - 1; i >= 0; i--)
			raw_bits.push_back(value[i]); // MSB first
	endtask

	// CRC-15 over raw_bits, zero start
	function automatic logic [14:0] crc15();
		logic [14:0] reg_val;
		logic feedback;
		int i;
		reg_val = '0;
		for (i = 0; i < raw_bits.size(); i++)
		begin
			feedback = raw_bits[i] ^ reg_val[14];
			reg_val = {reg_val[13:0], 1'b0};
			if (feedback)
				reg_val = reg_val ^ `CAN_CRC_POLY;
		end
		return reg_val;
	endfunction

	task automatic build_frame(input can_frame_t f, input logic [3:0] dlc_code,
		input logic flip_crc, input logic ack_bit, input int ifs_len);
		logic [14:0] crc_val;
		int n_bytes;
		int run;
		logic last;
		int i;
		raw_bits = {};
		tx_bits = {};
		stuff_pos = {};
		n_bytes = f.rtr ? 0 : ((dlc_code > 8) ? 8 : dlc_code);
		raw_bits.push_back(1'b0); // SOF
		if (f.ide)
		begin
			push_field(f.id.ext.id_a, `CAN_LEN_ID_A);
			raw_bits.push_back(1'b1); // SRR
			raw_bits.push_back(1'b1); // IDE
			push_field(f.id.ext.id_b, `CAN_LEN_ID_B);
			raw_bits.push_back(f.rtr);
			raw_bits.push_back(1'b0); // r1
		end
		else
		begin
			push_field(f.id.std.id, `CAN_LEN_ID_A);
			raw_bits.push_back(f.rtr);
			raw_bits.push_back(1'b0); // IDE
		end
		raw_bits.push_back(1'b0); // r0
		push_field(dlc_code, `CAN_LEN_DLC);
		push_field(f.data >> (64 - 8 * n_bytes), 8 * n_bytes);
		crc_val = crc15();
		if (flip_crc)
			crc_val[0] = !crc_val[0];
		push_field(crc_val, `CAN_LEN_CRC);
		// Stuffing, SOF through last CRC bit
		run = 0;
		last = 1'b1;
		for (i = 0; i < raw_bits.size(); i++)
		begin
			tx_bits.push_back(raw_bits[i]);
			run = (raw_bits[i] == last) ? run + 1 : 1;
			last = raw_bits[i];
			if (run == `CAN_STUFF_RUN)
			begin
				stuff_pos.push_back(tx_bits.size());
				tx_bits.push_back(!last);
				last = !last; // Stuff bit opens a new run
				run = 1;
			end
		end
		tx_bits.push_back(1'b1); // CRC delimiter
		tx_bits.push_back(ack_bit);
		repeat (1 + `CAN_LEN_EOF + ifs_len)
			tx_bits.push_back(1'b1); // ACK delimiter, EOF, intermission
	endtask

	task automatic send_frame(input can_frame_t f, input logic [3:0] dlc_code, input int ifs_len);
		build_frame(f, dlc_code, 1'b0, 1'b0, ifs_len);
		send_tx();
	endtask

	// ==========================================================================
	// Expected frames and compare tasks
	// ==========================================================================

	function automatic logic [63:0] random_data(input int n_bytes);
		logic [63:0] value;
		value = {$urandom(), $urandom()};
		if (n_bytes < 8)
			value = value & ~(64'hFFFF_FFFF_FFFF_FFFF >> (8 * n_bytes)); // Unused bytes zero
		return value;
	endfunction

	function automatic can_frame_t std_frame(input logic [10:0] id_val,
		input logic [3:0] dlc_code, input logic rtr_bit);
		can_frame_t f;
		f = '0;
		f.id.std.id = id_val;
		f.rtr = rtr_bit;
		f.dlc = (dlc_code > 8) ? 4'd8 : dlc_code; // Clamped
		f.data = rtr_bit ? '0 : random_data(f.dlc);
		return f;
	endfunction

	function automatic can_frame_t ext_frame(input logic [3:0] dlc_code, input logic rtr_bit);
		can_frame_t f;
		f = '0;
		f.id.ext.id_a = 11'($urandom());
		f.id.ext.id_b = 18'($urandom());
		f.ide = 1'b1;
		f.rtr = rtr_bit;
		f.dlc = (dlc_code > 8) ? 4'd8 : dlc_code;
		f.data = rtr_bit ? '0 : random_data(f.dlc);
		return f;
	endfunction

	task automatic check_frame(input can_frame_t expected);
		can_frame_t got;
		int n;
		n = 0;
		while (got_frames.size() == 0 && n < result_wait)
		begin
			@(posedge clock);
			n++;
		end
		if (got_frames.size() == 0)
			stop_run("No frame_valid pulse for a frame that should have decoded");
		got = got_frames.pop_front();
		if (got !== expected)
			stop_run($sformatf({"Mismatch at %0t: frame id %h ide %b rtr %b dlc %0d data %h,",
				" expected id %h ide %b rtr %b dlc %0d data %h"}, $time,
				got.id, got.ide, got.rtr, got.dlc, got.data,
				expected.id, expected.ide, expected.rtr, expected.dlc, expected.data));
	endtask

	task automatic check_error(input can_error_e expected);
		can_error_e got;
		int n;
		n = 0;
		while (got_errors.size() == 0 && n < result_wait)
		begin
			@(posedge clock);
			n++;
		end
		if (got_errors.size() == 0)
			stop_run("No error_valid pulse for a frame that should have failed");
		got = got_errors.pop_front();
		if (got !== expected)
			stop_run($sformatf("Mismatch at %0t: error code %s, expected %s",
				$time, got.name(), expected.name()));
	endtask

	// No pulse left over
	task automatic expect_quiet();
		if (got_frames.size() != 0)
			stop_run("A frame_valid pulse came where none was expected");
		if (got_errors.size() != 0)
			stop_run($sformatf("An error_valid pulse with code %s came where none was expected",
				got_errors[0].name()));
	endtask

	task automatic send_checked(input can_frame_t f, input logic [3:0] dlc_code);
		send_frame(f, dlc_code, full_ifs);
		check_frame(f);
		expect_quiet();
	endtask

	// ==========================================================================
	// Directed tests
	// ==========================================================================

	task automatic test_standard_frames();
		int d;
		for (d = 0; d <= 8; d++)
			send_checked(std_frame(11'($urandom()), 4'(d), 1'b0), 4'(d));
	endtask

	task automatic test_extended_frames();
		send_checked(ext_frame(4'd2, 1'b0), 4'd2);
		send_checked(ext_frame(4'd5, 1'b0), 4'd5);
		send_checked(ext_frame(4'd8, 1'b0), 4'd8);
	endtask

	task automatic test_remote_and_long_dlc();
		send_checked(std_frame(11'($urandom()), 4'd3, 1'b1), 4'd3);
		send_checked(ext_frame(4'd6, 1'b1), 4'd6);
		send_checked(std_frame(11'($urandom()), 4'd9, 1'b0), 4'd9); // Reads back as 8
		send_checked(std_frame(11'($urandom()), 4'd15, 1'b0), 4'd15);
	endtask

	task automatic test_stuff_error();
		build_frame(std_frame(11'h000, 4'd1, 1'b0), 4'd1, 1'b0, 1'b0, full_ifs);
		if (stuff_pos.size() == 0)
			stop_run("The stuff error frame holds no stuff bit to corrupt");
		tx_bits[stuff_pos[0]] = !tx_bits[stuff_pos[0]]; // Sixth equal bit
		send_tx();
		check_error(err_stuff);
		send_idle(`CAN_IDLE_RUN);
		expect_quiet();
		send_checked(std_frame(11'($urandom()), 4'd4, 1'b0), 4'd4);
	endtask

	task automatic test_crc_and_ack_errors();
		build_frame(std_frame(11'($urandom()), 4'd2, 1'b0), 4'd2, 1'b1, 1'b0, full_ifs);
		send_tx();
		check_error(err_crc);
		send_idle(`CAN_IDLE_RUN);
		expect_quiet();
		send_checked(ext_frame(4'd3, 1'b0), 4'd3);
		// Nobody acknowledges
		build_frame(std_frame(11'($urandom()), 4'd5, 1'b0), 4'd5, 1'b0, 1'b1, full_ifs);
		send_tx();
		check_error(err_form);
		send_idle(`CAN_IDLE_RUN);
		expect_quiet();
		send_checked(std_frame(11'($urandom()), 4'd7, 1'b0), 4'd7);
	endtask

	task automatic test_back_to_back();
		can_frame_t first;
		can_frame_t second;
		first = std_frame(11'($urandom()), 4'd3, 1'b0);
		second = ext_frame(4'd4, 1'b0);
		send_frame(first, 4'd3, `CAN_LEN_INTERFRAME); // Next SOF in third intermission bit
		send_frame(second, 4'd4, full_ifs);
		check_frame(first);
		check_frame(second);
		expect_quiet();
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		rx_bit = 1'b1;
		sample_point = 1'b0;
		void'($urandom(87));
		repeat (8) @(posedge clock);
		#1 reset = 1'b0;
		send_idle(`CAN_IDLE_RUN);
		test_standard_frames();
		test_extended_frames();
		test_remote_and_long_dlc();
		test_stuff_error();
		test_crc_and_ack_errors();
		test_back_to_back();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+.
can_frame_pkg.sv
can_ctrl_pkg.sv
can_bit_destuffer.sv
can_frame_sequencer.sv
can_field_capture.sv
can_decoder_top.sv
tb_can_decoder.sv

/* Bender.yml */
package:
  name: can_decoder

sources:
  - include_dirs:
      - .
    files:
      - can_frame_pkg.sv
      - can_ctrl_pkg.sv
      - can_bit_destuffer.sv
      - can_frame_sequencer.sv
      - can_field_capture.sv
      - can_decoder_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_can_decoder.sv
